// File: Makefile
# Verilator build and run for the display testbench

VERILATOR ?= verilator
TOP       ?= disp_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: disp_channel_sel.sv
`timescale 1ns/1ps
`default_nettype none

module disp_channel_sel
    import disp_pkg::*;
(
    input  wire disp_src_e                     src,
    input  wire logic      [data_w-1:0]        cpu_num,
    input  wire logic      [num_digits-1:0]    cpu_blink,
    input  wire logic      [num_digits-1:0]    cpu_point,
    input  wire logic      [data_w-1:0]        test_data1,
    input  wire logic      [data_w-1:0]        test_data2,
    input  wire logic      [data_w-1:0]        test_data3,
    input  wire logic      [data_w-1:0]        test_data4,
    input  wire logic      [data_w-1:0]        test_data5,
    input  wire logic      [data_w-1:0]        test_data6,
    input  wire logic      [data_w-1:0]        test_data7,
    input  wire logic      [8*num_digits-1:0]  blink_in,
    input  wire logic      [8*num_digits-1:0]  point_in,
    output logic           [data_w-1:0]        disp_num,
    output logic           [num_digits-1:0]    blink_out,
    output logic           [num_digits-1:0]    point_out
);

    // Byte 0 of the mask inputs belongs to the CPU channel and
    // reaches us through the register block instead
    always_comb begin
        case (src)
            src_test1: begin
                disp_num  = test_data1;
                blink_out = blink_in[15:8];
                point_out = point_in[15:8];
            end
            src_test2: begin
                disp_num  = test_data2;
                blink_out = blink_in[23:16];
                point_out = point_in[23:16];
            end
            src_test3: begin
                disp_num  = test_data3;
                blink_out = blink_in[31:24];
                point_out = point_in[31:24];
            end
            src_test4: begin
                disp_num  = test_data4;
                blink_out = blink_in[39:32];
                point_out = point_in[39:32];
            end
            src_test5: begin
                disp_num  = test_data5;
                blink_out = blink_in[47:40];
                point_out = point_in[47:40];
            end
            src_test6: begin
                disp_num  = test_data6;
                blink_out = blink_in[55:48];
                point_out = point_in[55:48];
            end
            src_test7: begin
                disp_num  = test_data7;
                blink_out = blink_in[63:56];
                point_out = point_in[63:56];
            end
            default: begin
                disp_num  = cpu_num;
                blink_out = cpu_blink;
                point_out = cpu_point;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: disp_pkg.sv
`default_nettype none

package disp_pkg;

    ////////////////////
    // Display geometry
    ////////////////////

    localparam int num_digits = 8;
    localparam int data_w     = 32;

    // Digit index width
    localparam int digit_w = $clog2(num_digits);

    ////////////////////
    // Scan and blink timing
    ////////////////////

    // Short scan period keeps simulation quick
    localparam int scan_div  = 4;
    localparam int blink_div = 64;

    localparam int scan_cnt_w  = $clog2(scan_div);
    localparam int blink_cnt_w = $clog2(blink_div);

    ////////////////////
    // Reset values of the CPU channel
    ////////////////////

    localparam logic [data_w-1:0]     reset_data  = 32'hAA55_55AA;
    localparam logic [num_digits-1:0] reset_blink = 8'hFF;
    localparam logic [num_digits-1:0] reset_point = 8'h00;

    // All active low with the point in bit 7 above g..a
    localparam logic [7:0] seg_blank = 8'hFF;

    // Channel zero is the CPU register block
    typedef enum logic [2:0] {
        src_cpu,
        src_test1,
        src_test2,
        src_test3,
        src_test4,
        src_test5,
        src_test6,
        src_test7
    } disp_src_e;

endpackage

`default_nettype wire

// File: disp_props.sv
`timescale 1ns/1ps
`default_nettype none

module disp_props
    import disp_pkg::*;
(
    input wire logic                  clk,
    input wire logic                  rst_n,
    input wire logic [num_digits-1:0] anode,
    input wire logic [7:0]            seg,
    input wire logic [digit_w-1:0]    digit
);

    // Set once the outputs have been driven by one post-reset edge
    logic outs_live;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outs_live <= 1'b0;
        end else begin
            outs_live <= 1'b1;
        end
    end

    anode_one_cold: assert property (@(posedge clk) disable iff (!rst_n)
        outs_live |-> $onehot(~anode))
        else $error("anode is not one-cold");

    // Digit holds or moves to the next one, wrapping after the last
    digit_step: assert property (@(posedge clk) disable iff (!rst_n)
        (digit == $past(digit)) || (digit == digit_w'($past(digit) + 1)))
        else $error("digit index skipped or left its range");

    blank_when_idle: assert property (@(posedge clk)
        (anode == '1) |-> (seg == seg_blank))
        else $error("segments lit with no anode active");

endmodule

`default_nettype wire

// File: disp_regs.sv
`timescale 1ns/1ps
`default_nettype none

module disp_regs
    import disp_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  wr_en,
    input  wire logic [data_w-1:0]     cpu_data,
    input  wire logic [num_digits-1:0] blink_in0,
    input  wire logic [num_digits-1:0] point_in0,
    input  wire logic [data_w-1:0]     disp_num,
    output logic      [data_w-1:0]     cpu_num,
    output logic      [num_digits-1:0] cpu_blink,
    output logic      [num_digits-1:0] cpu_point
);

    // Data word follows the display when idle, so channel zero
    // resumes with whatever was last on view
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_num <= reset_data;
        end else if (wr_en) begin
            cpu_num <= cpu_data;
        end else begin
            cpu_num <= disp_num;
        end
    end

    // Masks only change on a write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_blink <= reset_blink;
            cpu_point <= reset_point;
        end else if (wr_en) begin
            cpu_blink <= blink_in0;
            cpu_point <= point_in0;
        end
    end

endmodule

`default_nettype wire

// File: disp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module disp_tb
    import disp_pkg::*;
();

    logic                    clk;
    logic                    rst_n;
    logic                    wr_en;
    disp_src_e               src;
    logic [8*num_digits-1:0] point_in;
    logic [8*num_digits-1:0] blink_in;
    logic [data_w-1:0]       cpu_data;
    logic [data_w-1:0]       test_data [1:num_digits-1];
    logic [data_w-1:0]       disp_num;
    logic [num_digits-1:0]   point_out;
    logic [num_digits-1:0]   blink_out;
    logic [num_digits-1:0]   anode;
    logic [7:0]              seg;

    int    seed;
    string test_name;

    // Reference state for the CPU channel and the scanner
    logic [data_w-1:0]     m_cpu_num;
    logic [num_digits-1:0] m_cpu_blink;
    logic [num_digits-1:0] m_cpu_point;
    int                    m_scan;
    int                    m_digit;
    int                    m_blink_cnt;
    logic                  m_phase;
    logic [num_digits-1:0] m_anode;
    logic [7:0]            m_seg;

    disp_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .src        (src),
        .point_in   (point_in),
        .blink_in   (blink_in),
        .cpu_data   (cpu_data),
        .test_data1 (test_data[1]),
        .test_data2 (test_data[2]),
        .test_data3 (test_data[3]),
        .test_data4 (test_data[4]),
        .test_data5 (test_data[5]),
        .test_data6 (test_data[6]),
        .test_data7 (test_data[7]),
        .disp_num   (disp_num),
        .point_out  (point_out),
        .blink_out  (blink_out),
        .anode      (anode),
        .seg        (seg)
    );

    bind seg7_scan disp_props u_props (
        .clk   (clk),
        .rst_n (rst_n),
        .anode (anode),
        .seg   (seg),
        .digit (digit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_num(input string what, input logic [data_w-1:0] exp,
                             input logic [data_w-1:0] act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("Test failed");
            $fatal(1, "word mismatch on %s", what);
        end
    endtask

    task automatic check_mask(input string what, input logic [num_digits-1:0] exp,
                              input logic [num_digits-1:0] act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("Test failed");
            $fatal(1, "mask mismatch on %s", what);
        end
    endtask

    task automatic check_seg(input logic [num_digits-1:0] exp_anode, input logic [7:0] exp_seg,
                             input logic [num_digits-1:0] act_anode, input logic [7:0] act_seg);
        if (act_anode !== exp_anode || act_seg !== exp_seg) begin
            $display("Fail %s anode/seg: expected %h/%h, actual %h/%h", test_name,
                     exp_anode, exp_seg, act_anode, act_seg);
            $display("Test failed");
            $fatal(1, "scan output mismatch");
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Active-high lit segments g..a
    function automatic logic [6:0] seg_on(input logic [3:0] n);
        case (n)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    task automatic select_model(output logic [data_w-1:0] num,
                                output logic [num_digits-1:0] blk,
                                output logic [num_digits-1:0] pnt);
        int idx;
        idx = int'(src);
        if (idx == 0) begin
            num = m_cpu_num;
            blk = m_cpu_blink;
            pnt = m_cpu_point;
        end else begin
            num = test_data[idx];
            blk = blink_in[8*idx +: 8];
            pnt = point_in[8*idx +: 8];
        end
    endtask

    // Called just after a rising edge, before new inputs are driven
    task automatic model_edge();
        logic [data_w-1:0]     sn;
        logic [num_digits-1:0] sb;
        logic [num_digits-1:0] sp;
        if (!rst_n) begin
            m_cpu_num   = 32'hAA55_55AA;
            m_cpu_blink = 8'hFF;
            m_cpu_point = 8'h00;
            m_scan      = 0;
            m_digit     = 0;
            m_blink_cnt = 0;
            m_phase     = 1'b1;
            m_anode     = 8'hFF;
            m_seg       = 8'hFF;
        end else begin
            select_model(sn, sb, sp);
            m_anode = ~(8'h01 << m_digit);
            if (sb[m_digit] && !m_phase) begin
                m_seg = 8'hFF;
            end else begin
                m_seg = {~sp[m_digit], ~seg_on(sn[4*m_digit +: 4])};
            end
            if (wr_en) begin
                m_cpu_num   = cpu_data;
                m_cpu_blink = blink_in[7:0];
                m_cpu_point = point_in[7:0];
            end else begin
                m_cpu_num = sn;
            end
            if (m_scan == scan_div - 1) begin
                m_scan  = 0;
                m_digit = (m_digit + 1) % num_digits;
            end else begin
                m_scan = m_scan + 1;
            end
            if (m_blink_cnt == blink_div - 1) begin
                m_blink_cnt = 0;
                m_phase     = ~m_phase;
            end else begin
                m_blink_cnt = m_blink_cnt + 1;
            end
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    function automatic disp_src_e rand_test_src();
        int r;
        r = $unsigned($random(seed)) % 7;
        return disp_src_e'(3'(r + 1));
    endfunction

    function automatic logic rand_write();
        return ($random(seed) % 4) == 0;
    endfunction

    task automatic drive_inputs(input disp_src_e s, input logic w);
        src      = s;
        wr_en    = w;
        cpu_data = $random(seed);
        for (int k = 1; k < num_digits; k++) begin
            test_data[k] = $random(seed);
        end
        blink_in = {$random(seed), $random(seed)};
        point_in = {$random(seed), $random(seed)};
    endtask

    task automatic check_outputs();
        logic [data_w-1:0]     sn;
        logic [num_digits-1:0] sb;
        logic [num_digits-1:0] sp;
        select_model(sn, sb, sp);
        check_num("disp_num", sn, disp_num);
        check_mask("blink_out", sb, blink_out);
        check_mask("point_out", sp, point_out);
        check_seg(m_anode, m_seg, anode, seg);
    endtask

    // One clock of model update and new inputs, compared at the falling edge
    task automatic step_cycle(input disp_src_e s, input logic w);
        @(posedge clk);
        #1;
        model_edge();
        drive_inputs(s, w);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic wait_first_digit();
        int n;
        n = 0;
        while (anode !== 8'hFE) begin
            if (n == 64) begin
                $display("Timeout: anode did not reach digit 0 within 64 cycles");
                $display("Test failed");
                $fatal(1, "anode wait timeout");
            end
            step_cycle(src_cpu, 1'b0);
            n = n + 1;
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        disp_src_e             k;
        logic [data_w-1:0]     w_data;
        logic [num_digits-1:0] w_blink;
        logic [num_digits-1:0] w_point;
        int                    idx;

        seed      = 72492;
        rst_n     = 1'b0;
        wr_en     = 1'b0;
        src       = src_cpu;
        cpu_data  = '0;
        blink_in  = '0;
        point_in  = '0;
        for (int i = 1; i < num_digits; i++) begin
            test_data[i] = '0;
        end

        test_name = "reset";
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            model_edge();
            drive_inputs(src_cpu, 1'b0);
            if (i == 7) begin
                rst_n = 1'b1;
            end
        end
        @(negedge clk);
        check_num("disp_num", 32'hAA55_55AA, disp_num);
        check_mask("blink_out", 8'hFF, blink_out);
        check_mask("point_out", 8'h00, point_out);
        check_seg(8'hFF, 8'hFF, anode, seg);
        check_outputs();

        test_name = "test channel select";
        repeat (200) begin
            k = rand_test_src();
            step_cycle(k, rand_write());
            idx = int'(k);
            check_num("disp_num", test_data[idx], disp_num);
            check_mask("blink_out", blink_in[8*idx +: 8], blink_out);
            check_mask("point_out", point_in[8*idx +: 8], point_out);
        end

        test_name = "cpu write";
        repeat (20) begin
            step_cycle(src_cpu, 1'b1);
            w_data  = cpu_data;
            w_blink = blink_in[7:0];
            w_point = point_in[7:0];
            step_cycle(src_cpu, 1'b0);
            check_num("disp_num", w_data, disp_num);
            check_mask("blink_out", w_blink, blink_out);
            check_mask("point_out", w_point, point_out);
            // Masks hold while idle
            repeat (3) step_cycle(src_cpu, 1'b0);
            check_num("disp_num", w_data, disp_num);
            check_mask("blink_out", w_blink, blink_out);
            check_mask("point_out", w_point, point_out);
        end

        test_name = "snapshot";
        repeat (10) begin
            k = rand_test_src();
            repeat (5) step_cycle(k, 1'b0);
            w_data = test_data[int'(k)];
            step_cycle(src_cpu, 1'b0);
            check_num("disp_num", w_data, disp_num);
        end

        // Long mixed run covers several blink periods
        test_name = "scan and decode";
        repeat (400) begin
            if (($random(seed) % 3) == 0) begin
                step_cycle(src_cpu, rand_write());
            end else begin
                step_cycle(rand_test_src(), rand_write());
            end
        end
        wait_first_digit();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: disp_top.sv
`timescale 1ns/1ps
`default_nettype none

module disp_top
    import disp_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     wr_en,
    input  wire disp_src_e                src,
    input  wire logic [8*num_digits-1:0]  point_in,
    input  wire logic [8*num_digits-1:0]  blink_in,
    input  wire logic [data_w-1:0]        cpu_data,
    input  wire logic [data_w-1:0]        test_data1,
    input  wire logic [data_w-1:0]        test_data2,
    input  wire logic [data_w-1:0]        test_data3,
    input  wire logic [data_w-1:0]        test_data4,
    input  wire logic [data_w-1:0]        test_data5,
    input  wire logic [data_w-1:0]        test_data6,
    input  wire logic [data_w-1:0]        test_data7,
    output logic      [data_w-1:0]        disp_num,
    output logic      [num_digits-1:0]    point_out,
    output logic      [num_digits-1:0]    blink_out,
    output logic      [num_digits-1:0]    anode,
    output logic      [7:0]               seg
);

    logic [data_w-1:0]     cpu_num;
    logic [num_digits-1:0] cpu_blink;
    logic [num_digits-1:0] cpu_point;

    // CPU channel reloads from the displayed number when idle
    disp_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .cpu_data  (cpu_data),
        .blink_in0 (blink_in[7:0]),
        .point_in0 (point_in[7:0]),
        .disp_num  (disp_num),
        .cpu_num   (cpu_num),
        .cpu_blink (cpu_blink),
        .cpu_point (cpu_point)
    );

    disp_channel_sel u_sel (
        .src        (src),
        .cpu_num    (cpu_num),
        .cpu_blink  (cpu_blink),
        .cpu_point  (cpu_point),
        .test_data1 (test_data1),
        .test_data2 (test_data2),
        .test_data3 (test_data3),
        .test_data4 (test_data4),
        .test_data5 (test_data5),
        .test_data6 (test_data6),
        .test_data7 (test_data7),
        .blink_in   (blink_in),
        .point_in   (point_in),
        .disp_num   (disp_num),
        .blink_out  (blink_out),
        .point_out  (point_out)
    );

    seg7_scan u_scan (
        .clk        (clk),
        .rst_n      (rst_n),
        .disp_num   (disp_num),
        .blink_mask (blink_out),
        .point_mask (point_out),
        .anode      (anode),
        .seg        (seg)
    );

endmodule

`default_nettype wire

// File: seg7_decode.sv
`timescale 1ns/1ps
`default_nettype none

module seg7_decode (
    input  wire logic [3:0] nibble,
    output logic      [6:0] segs
);

    // Patterns are g..a and a zero lights the segment
    always_comb begin
        case (nibble)
            4'h0: segs = 7'b100_0000;
            4'h1: segs = 7'b111_1001;
            4'h2: segs = 7'b010_0100;
            4'h3: segs = 7'b011_0000;
            4'h4: segs = 7'b001_1001;
            4'h5: segs = 7'b001_0010;
            4'h6: segs = 7'b000_0010;
            4'h7: segs = 7'b111_1000;
            4'h8: segs = 7'b000_0000;
            4'h9: segs = 7'b001_0000;
            // Lower case b and d keep the letters apart from 8 and 0
            4'hA: segs = 7'b000_1000;
            4'hB: segs = 7'b000_0011;
            4'hC: segs = 7'b100_0110;
            4'hD: segs = 7'b010_0001;
            4'hE: segs = 7'b000_0110;
            default: segs = 7'b000_1110;
        endcase
    end

endmodule

`default_nettype wire

// File: seg7_scan.sv
`timescale 1ns/1ps
`default_nettype none

module seg7_scan
    import disp_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [data_w-1:0]     disp_num,
    input  wire logic [num_digits-1:0] blink_mask,
    input  wire logic [num_digits-1:0] point_mask,
    output logic      [num_digits-1:0] anode,
    output logic      [7:0]            seg
);

    logic [scan_cnt_w-1:0]  scan_cnt;
    logic [digit_w-1:0]     digit;
    logic [blink_cnt_w-1:0] blink_cnt;
    logic                   blink_phase;
    logic [3:0]             nibble;
    logic [6:0]             digit_segs;
    logic [7:0]             seg_next;

    ////////////////////
    // Scan and blink dividers
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            digit    <= '0;
        end else if (scan_cnt == scan_cnt_w'(scan_div - 1)) begin
            scan_cnt <= '0;
            if (digit == digit_w'(num_digits - 1)) begin
                digit <= '0;
            end else begin
                digit <= digit + 1'b1;
            end
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // Phase high means blinking digits are lit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blink_cnt   <= '0;
            blink_phase <= 1'b1;
        end else if (blink_cnt == blink_cnt_w'(blink_div - 1)) begin
            blink_cnt   <= '0;
            blink_phase <= ~blink_phase;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    ////////////////////
    // Digit drive
    ////////////////////

    assign nibble = disp_num[{digit, 2'b00} +: 4];

    seg7_decode u_decode (
        .nibble (nibble),
        .segs   (digit_segs)
    );

    always_comb begin
        if (blink_mask[digit] && !blink_phase) begin
            seg_next = seg_blank;
        end else begin
            seg_next = {~point_mask[digit], digit_segs};
        end
    end

    // Outputs are registered so the pins change cleanly
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            anode <= '1;
            seg   <= seg_blank;
        end else begin
            anode <= ~(num_digits'(1) << digit);
            seg   <= seg_next;
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
disp_pkg.sv
seg7_decode.sv
disp_regs.sv
disp_channel_sel.sv
seg7_scan.sv
disp_top.sv
disp_props.sv
disp_tb.sv
